// ==== verilog/mmc_bb_reg_pkg.sv ====
`default_nettype none

package mmc_bb_reg_pkg;

  localparam int lb_width  = 8;
  localparam int adr_width = 3;

  typedef logic [lb_width-1:0]  lb_dat_t;
  typedef logic [adr_width-1:0] lb_adr_t;

  // Register map
  localparam lb_adr_t reg_dat_o    = 3'd0;
  localparam lb_adr_t reg_dat_i    = 3'd1;
  localparam lb_adr_t reg_cmd_o    = 3'd2;
  localparam lb_adr_t reg_cmd_i    = 3'd3;
  localparam lb_adr_t reg_oens     = 3'd4;
  localparam lb_adr_t reg_status   = 3'd5;
  localparam lb_adr_t reg_adv_type = 3'd6;
  // Write only and reads as zero
  localparam lb_adr_t reg_adv_man  = 3'd7;

  // Bits in reg_oens
  localparam int oen_cmd_bit = 0;
  localparam int oen_dat_bit = 1;

  // Bits in reg_status
  localparam int st_detect_bit = 0;
  localparam int st_done_bit   = 4;

endpackage

`default_nettype wire

// ==== verilog/mmc_bb_seq_pkg.sv ====
`default_nettype none

package mmc_bb_seq_pkg;

  // Advance mode where unknown codes act as manual
  typedef logic [2:0] adv_type_t;

  localparam adv_type_t adv_manual = 3'd0;
  localparam adv_type_t adv_cmd_rd = 3'd1;
  localparam adv_type_t adv_cmd_wr = 3'd2;
  localparam adv_type_t adv_dat_rd = 3'd3;
  localparam adv_type_t adv_dat_wr = 3'd4;

  // lb_clk cycles per card clock pulse
  localparam int clk_phases = 4;

  typedef logic [1:0] phase_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/mmc_line_if.sv ====
`default_nettype none

interface mmc_line_if;

  // Driven by the register block
  logic                    cmd_o;
  logic                    cmd_oen;
  mmc_bb_reg_pkg::lb_dat_t data_o;
  logic                    data_oen;

  // Sampled values held by the pin block
  logic                    cmd_i;
  mmc_bb_reg_pkg::lb_dat_t data_i;

  modport regs (
    output cmd_o,
    output cmd_oen,
    output data_o,
    output data_oen,
    input  cmd_i,
    input  data_i
  );

  modport pins (
    input  cmd_o,
    input  cmd_oen,
    input  data_o,
    input  data_oen,
    output cmd_i,
    output data_i
  );

endinterface

`default_nettype wire

// ==== verilog/mmc_bb_regs.sv ====
`default_nettype none

module mmc_bb_regs (
  input  wire                          lb_clk,
  input  wire                          lb_rst,
  input  wire                          lb_stb_i,
  input  wire                          lb_we_i,
  input  wire mmc_bb_reg_pkg::lb_adr_t lb_adr_i,
  input  wire mmc_bb_reg_pkg::lb_dat_t lb_dat_i,
  output mmc_bb_reg_pkg::lb_dat_t      lb_dat_o,
  input  wire                          mmc_detect_i,
  input  wire                          trans_done_i,
  output logic                         advance_o,
  mmc_line_if.regs                     line
);

  mmc_bb_seq_pkg::adv_type_t adv_type;
  mmc_bb_reg_pkg::lb_dat_t   status;
  mmc_bb_reg_pkg::lb_dat_t   oens;
  logic                      wr;
  logic                      rd;

  assign wr = lb_stb_i & lb_we_i;
  assign rd = lb_stb_i & ~lb_we_i;

  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      line.data_o   <= '0;
      line.cmd_o    <= 1'b0;
      line.cmd_oen  <= 1'b0;
      line.data_oen <= 1'b0;
      adv_type      <= mmc_bb_seq_pkg::adv_manual;
    end else if (wr) begin
      case (lb_adr_i)
        mmc_bb_reg_pkg::reg_dat_o: begin
          line.data_o <= lb_dat_i;
        end
        mmc_bb_reg_pkg::reg_cmd_o: begin
          line.cmd_o <= lb_dat_i[0];
        end
        mmc_bb_reg_pkg::reg_oens: begin
          line.cmd_oen  <= lb_dat_i[mmc_bb_reg_pkg::oen_cmd_bit];
          line.data_oen <= lb_dat_i[mmc_bb_reg_pkg::oen_dat_bit];
        end
        mmc_bb_reg_pkg::reg_adv_type: begin
          adv_type <= lb_dat_i[2:0];
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    status = '0;
    status[mmc_bb_reg_pkg::st_detect_bit] = mmc_detect_i;
    status[mmc_bb_reg_pkg::st_done_bit]   = trans_done_i;
    oens = '0;
    oens[mmc_bb_reg_pkg::oen_cmd_bit] = line.cmd_oen;
    oens[mmc_bb_reg_pkg::oen_dat_bit] = line.data_oen;
  end

  // Read data follows the address with no register stage
  always_comb begin
    case (lb_adr_i)
      mmc_bb_reg_pkg::reg_dat_o:    lb_dat_o = line.data_o;
      mmc_bb_reg_pkg::reg_dat_i:    lb_dat_o = line.data_i;
      mmc_bb_reg_pkg::reg_cmd_o:    lb_dat_o = {7'b0, line.cmd_o};
      mmc_bb_reg_pkg::reg_cmd_i:    lb_dat_o = {7'b0, line.cmd_i};
      mmc_bb_reg_pkg::reg_oens:     lb_dat_o = oens;
      mmc_bb_reg_pkg::reg_status:   lb_dat_o = status;
      mmc_bb_reg_pkg::reg_adv_type: lb_dat_o = {5'b0, adv_type};
      default:                      lb_dat_o = '0;
    endcase
  end

  // Manual strobe or the access matching the advance mode
  always_comb begin
    advance_o = wr && (lb_adr_i == mmc_bb_reg_pkg::reg_adv_man);
    case (adv_type)
      mmc_bb_seq_pkg::adv_cmd_rd: begin
        if (rd && lb_adr_i == mmc_bb_reg_pkg::reg_cmd_i) advance_o = 1'b1;
      end
      mmc_bb_seq_pkg::adv_cmd_wr: begin
        if (wr && lb_adr_i == mmc_bb_reg_pkg::reg_cmd_o) advance_o = 1'b1;
      end
      mmc_bb_seq_pkg::adv_dat_rd: begin
        if (rd && lb_adr_i == mmc_bb_reg_pkg::reg_dat_i) advance_o = 1'b1;
      end
      mmc_bb_seq_pkg::adv_dat_wr: begin
        if (wr && lb_adr_i == mmc_bb_reg_pkg::reg_dat_o) advance_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/mmc_clk_seq.sv ====
`default_nettype none

module mmc_clk_seq (
  input  wire  lb_clk,
  input  wire  lb_rst,
  input  wire  advance_i,
  output logic mmc_clk_o,
  output logic trans_done_o,
  output logic sample_o
);

  localparam mmc_bb_seq_pkg::phase_cnt_t phase_load =
    mmc_bb_seq_pkg::phase_cnt_t'(mmc_bb_seq_pkg::clk_phases - 1);

  mmc_bb_seq_pkg::phase_cnt_t phase_cnt;

  // Counts 3, 2, 1, 0 and rests at zero
  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      phase_cnt <= '0;
    end else if (phase_cnt != '0) begin
      phase_cnt <= phase_cnt - 1'b1;
    end else if (advance_i) begin
      phase_cnt <= phase_load;
    end
  end

  // Low for the first half of the pulse so idle is high
  assign mmc_clk_o    = ~phase_cnt[1];
  assign trans_done_o = (phase_cnt == '0);
  // Card clock rising edge
  assign sample_o     = (phase_cnt == 2'd1);

endmodule

`default_nettype wire

// ==== verilog/mmc_line_io.sv ====
`default_nettype none

module mmc_line_io (
  input  wire                          lb_clk,
  input  wire                          lb_rst,
  input  wire                          sample_i,
  input  wire                          mmc_cmd_i,
  input  wire mmc_bb_reg_pkg::lb_dat_t mmc_data_i,
  output logic                         mmc_cmd_o,
  output logic                         mmc_cmd_oen_o,
  output mmc_bb_reg_pkg::lb_dat_t      mmc_data_o,
  output logic                         mmc_data_oen_o,
  mmc_line_if.pins                     line
);

  // Enables are active high
  assign mmc_cmd_o      = line.cmd_o;
  assign mmc_cmd_oen_o  = line.cmd_oen;
  assign mmc_data_o     = line.data_o;
  assign mmc_data_oen_o = line.data_oen;

  // Capture the card lines on the card clock rising edge
  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      line.cmd_i  <= 1'b0;
      line.data_i <= '0;
    end else if (sample_i) begin
      line.cmd_i  <= mmc_cmd_i;
      line.data_i <= mmc_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mmc_bb.sv ====
`default_nettype none

module mmc_bb (
  input  wire                          lb_clk,
  input  wire                          lb_rst,
  input  wire                          lb_stb_i,
  input  wire                          lb_we_i,
  input  wire mmc_bb_reg_pkg::lb_adr_t lb_adr_i,
  input  wire mmc_bb_reg_pkg::lb_dat_t lb_dat_i,
  output mmc_bb_reg_pkg::lb_dat_t      lb_dat_o,
  output logic                         mmc_clk_o,
  output logic                         mmc_cmd_o,
  input  wire                          mmc_cmd_i,
  output logic                         mmc_cmd_oen_o,
  output mmc_bb_reg_pkg::lb_dat_t      mmc_data_o,
  input  wire mmc_bb_reg_pkg::lb_dat_t mmc_data_i,
  output logic                         mmc_data_oen_o,
  input  wire                          mmc_detect_i
);

  logic advance;
  logic trans_done;
  logic sample;

  mmc_line_if line ();

  mmc_bb_regs regs_i (
    .lb_clk       (lb_clk),
    .lb_rst       (lb_rst),
    .lb_stb_i     (lb_stb_i),
    .lb_we_i      (lb_we_i),
    .lb_adr_i     (lb_adr_i),
    .lb_dat_i     (lb_dat_i),
    .lb_dat_o     (lb_dat_o),
    .mmc_detect_i (mmc_detect_i),
    .trans_done_i (trans_done),
    .advance_o    (advance),
    .line         (line.regs)
  );

  mmc_clk_seq clk_seq_i (
    .lb_clk       (lb_clk),
    .lb_rst       (lb_rst),
    .advance_i    (advance),
    .mmc_clk_o    (mmc_clk_o),
    .trans_done_o (trans_done),
    .sample_o     (sample)
  );

  mmc_line_io line_io_i (
    .lb_clk         (lb_clk),
    .lb_rst         (lb_rst),
    .sample_i       (sample),
    .mmc_cmd_i      (mmc_cmd_i),
    .mmc_data_i     (mmc_data_i),
    .mmc_cmd_o      (mmc_cmd_o),
    .mmc_cmd_oen_o  (mmc_cmd_oen_o),
    .mmc_data_o     (mmc_data_o),
    .mmc_data_oen_o (mmc_data_oen_o),
    .line           (line.pins)
  );

endmodule

`default_nettype wire

// ==== bench/mmc_bb_tb.sv ====
`default_nettype none

module mmc_bb_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_trans    = 400;
  localparam int n_directed = 13;
  localparam int period_ns  = 4;
  localparam int limit_cyc  = (n_trans + n_directed) * 8 + 100;

  logic                      lb_clk;
  logic                      lb_rst;
  logic                      lb_stb_i;
  logic                      lb_we_i;
  mmc_bb_reg_pkg::lb_adr_t   lb_adr_i;
  mmc_bb_reg_pkg::lb_dat_t   lb_dat_i;
  mmc_bb_reg_pkg::lb_dat_t   lb_dat_o;
  logic                      mmc_clk_o;
  logic                      mmc_cmd_o;
  logic                      mmc_cmd_i;
  logic                      mmc_cmd_oen_o;
  mmc_bb_reg_pkg::lb_dat_t   mmc_data_o;
  mmc_bb_reg_pkg::lb_dat_t   mmc_data_i;
  logic                      mmc_data_oen_o;
  logic                      mmc_detect_i;

  // Reference model state
  mmc_bb_reg_pkg::lb_dat_t    dat_o_m;
  mmc_bb_reg_pkg::lb_dat_t    dat_i_m;
  logic                       cmd_o_m;
  logic                       cmd_i_m;
  logic                       cmd_oen_m;
  logic                       dat_oen_m;
  mmc_bb_seq_pkg::adv_type_t  adv_m;
  mmc_bb_seq_pkg::phase_cnt_t phase_m;

  logic [31:0] rng;
  int          checks;
  int          errors;
  int          pulses;
  int          dropped;

  mmc_bb mmc_bb_i (
    .lb_clk         (lb_clk),
    .lb_rst         (lb_rst),
    .lb_stb_i       (lb_stb_i),
    .lb_we_i        (lb_we_i),
    .lb_adr_i       (lb_adr_i),
    .lb_dat_i       (lb_dat_i),
    .lb_dat_o       (lb_dat_o),
    .mmc_clk_o      (mmc_clk_o),
    .mmc_cmd_o      (mmc_cmd_o),
    .mmc_cmd_i      (mmc_cmd_i),
    .mmc_cmd_oen_o  (mmc_cmd_oen_o),
    .mmc_data_o     (mmc_data_o),
    .mmc_data_i     (mmc_data_i),
    .mmc_data_oen_o (mmc_data_oen_o),
    .mmc_detect_i   (mmc_detect_i)
  );

  always #2 lb_clk = ~lb_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_byte(input string name, input mmc_bb_reg_pkg::lb_dat_t exp,
                            input mmc_bb_reg_pkg::lb_dat_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_adv(input string name, input mmc_bb_seq_pkg::adv_type_t exp,
                           input mmc_bb_seq_pkg::adv_type_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  // Read value that the register map defines for an address
  function automatic mmc_bb_reg_pkg::lb_dat_t expected_read(input mmc_bb_reg_pkg::lb_adr_t adr);
    mmc_bb_reg_pkg::lb_dat_t v;
    v = '0;
    case (adr)
      mmc_bb_reg_pkg::reg_dat_o:    v = dat_o_m;
      mmc_bb_reg_pkg::reg_dat_i:    v = dat_i_m;
      mmc_bb_reg_pkg::reg_cmd_o:    v[0] = cmd_o_m;
      mmc_bb_reg_pkg::reg_cmd_i:    v[0] = cmd_i_m;
      mmc_bb_reg_pkg::reg_oens: begin
        v[mmc_bb_reg_pkg::oen_cmd_bit] = cmd_oen_m;
        v[mmc_bb_reg_pkg::oen_dat_bit] = dat_oen_m;
      end
      mmc_bb_reg_pkg::reg_status: begin
        v[mmc_bb_reg_pkg::st_detect_bit] = mmc_detect_i;
        v[mmc_bb_reg_pkg::st_done_bit]   = (phase_m == 2'd0);
      end
      mmc_bb_reg_pkg::reg_adv_type: v[2:0] = adv_m;
      default:                      v = '0;
    endcase
    return v;
  endfunction

  function automatic logic access_advances(input logic wr, input logic rd,
                                           input mmc_bb_reg_pkg::lb_adr_t adr);
    logic hit;
    hit = wr && adr == mmc_bb_reg_pkg::reg_adv_man;
    if (adv_m == mmc_bb_seq_pkg::adv_cmd_rd && rd && adr == mmc_bb_reg_pkg::reg_cmd_i) hit = 1'b1;
    if (adv_m == mmc_bb_seq_pkg::adv_cmd_wr && wr && adr == mmc_bb_reg_pkg::reg_cmd_o) hit = 1'b1;
    if (adv_m == mmc_bb_seq_pkg::adv_dat_rd && rd && adr == mmc_bb_reg_pkg::reg_dat_i) hit = 1'b1;
    if (adv_m == mmc_bb_seq_pkg::adv_dat_wr && wr && adr == mmc_bb_reg_pkg::reg_dat_o) hit = 1'b1;
    return hit;
  endfunction

  // Drive and check one lb_clk cycle, then step the model across the rising edge
  task automatic bus_cycle(input logic stb, input logic we, input mmc_bb_reg_pkg::lb_adr_t adr,
                           input mmc_bb_reg_pkg::lb_dat_t dat, input logic card_cmd,
                           input mmc_bb_reg_pkg::lb_dat_t card_dat, input logic detect);
    logic wr;
    logic rd;
    logic adv;
    @(negedge lb_clk);
    lb_stb_i     = stb;
    lb_we_i      = we;
    lb_adr_i     = adr;
    lb_dat_i     = dat;
    mmc_detect_i = detect;
    // Card only moves while the card clock is idle high
    if (phase_m == 2'd0) begin
      mmc_cmd_i  = card_cmd;
      mmc_data_i = card_dat;
    end
    #1;
    check_byte("lb_dat_o", expected_read(adr), lb_dat_o);
    check_bit("mmc_clk_o", phase_m == 2'd1 || phase_m == 2'd0, mmc_clk_o);
    check_bit("mmc_cmd_o", cmd_o_m, mmc_cmd_o);
    check_bit("mmc_cmd_oen_o", cmd_oen_m, mmc_cmd_oen_o);
    check_byte("mmc_data_o", dat_o_m, mmc_data_o);
    check_bit("mmc_data_oen_o", dat_oen_m, mmc_data_oen_o);
    if (adr == mmc_bb_reg_pkg::reg_adv_type) begin
      check_adv("adv_type", adv_m, lb_dat_o[2:0]);
    end
    wr  = stb & we;
    rd  = stb & ~we;
    adv = access_advances(wr, rd, adr);
    if (phase_m == 2'd1) begin
      cmd_i_m = mmc_cmd_i;
      dat_i_m = mmc_data_i;
    end
    if (phase_m != 2'd0) begin
      phase_m = phase_m - 2'd1;
      if (adv) dropped++;
    end else if (adv) begin
      phase_m = 2'd3;
      pulses++;
    end
    if (wr) begin
      case (adr)
        mmc_bb_reg_pkg::reg_dat_o:    dat_o_m = dat;
        mmc_bb_reg_pkg::reg_cmd_o:    cmd_o_m = dat[0];
        mmc_bb_reg_pkg::reg_oens: begin
          cmd_oen_m = dat[mmc_bb_reg_pkg::oen_cmd_bit];
          dat_oen_m = dat[mmc_bb_reg_pkg::oen_dat_bit];
        end
        mmc_bb_reg_pkg::reg_adv_type: adv_m = dat[2:0];
        default: begin
        end
      endcase
    end
  endtask

  initial begin
    #(limit_cyc * period_ns);
    $display("Timeout: the run did not finish within %0d cycles", limit_cyc);
    $display("Test failures found");
    $finish;
  end

  initial begin
    lb_clk       = 1'b0;
    lb_rst       = 1'b1;
    lb_stb_i     = 1'b0;
    lb_we_i      = 1'b0;
    lb_adr_i     = '0;
    lb_dat_i     = '0;
    mmc_cmd_i    = 1'b0;
    mmc_data_i   = '0;
    mmc_detect_i = 1'b0;
    dat_o_m      = '0;
    dat_i_m      = '0;
    cmd_o_m      = 1'b0;
    cmd_i_m      = 1'b0;
    cmd_oen_m    = 1'b0;
    dat_oen_m    = 1'b0;
    adv_m        = mmc_bb_seq_pkg::adv_manual;
    phase_m      = '0;
    rng          = 32'h81d630fe;
    checks       = 0;
    errors       = 0;
    pulses       = 0;
    dropped      = 0;
    repeat (3) @(posedge lb_clk);
    @(negedge lb_clk);
    lb_rst = 1'b0;

    // Reset state and a manual pulse followed by read and write advances
    bus_cycle(1'b0, 1'b0, mmc_bb_reg_pkg::reg_status, 8'h00, 1'b1, 8'ha5, 1'b1);
    bus_cycle(1'b1, 1'b0, mmc_bb_reg_pkg::reg_adv_type, 8'h00, 1'b1, 8'ha5, 1'b0);
    bus_cycle(1'b1, 1'b1, mmc_bb_reg_pkg::reg_adv_man, 8'h00, 1'b1, 8'ha5, 1'b1);
    bus_cycle(1'b1, 1'b1, mmc_bb_reg_pkg::reg_dat_o, 8'h3c, 1'b0, 8'h00, 1'b1);
    bus_cycle(1'b0, 1'b0, mmc_bb_reg_pkg::reg_status, 8'h00, 1'b0, 8'h00, 1'b1);
    bus_cycle(1'b0, 1'b0, mmc_bb_reg_pkg::reg_status, 8'h00, 1'b0, 8'h00, 1'b1);
    bus_cycle(1'b0, 1'b0, mmc_bb_reg_pkg::reg_status, 8'h00, 1'b0, 8'h00, 1'b0);
    bus_cycle(1'b1, 1'b1, mmc_bb_reg_pkg::reg_adv_type, 8'h03, 1'b0, 8'h5a, 1'b0);
    bus_cycle(1'b1, 1'b0, mmc_bb_reg_pkg::reg_dat_i, 8'h00, 1'b0, 8'h5a, 1'b0);
    bus_cycle(1'b1, 1'b0, mmc_bb_reg_pkg::reg_dat_i, 8'h00, 1'b1, 8'hff, 1'b0);
    bus_cycle(1'b1, 1'b1, mmc_bb_reg_pkg::reg_adv_type, 8'h04, 1'b1, 8'hff, 1'b0);
    bus_cycle(1'b1, 1'b1, mmc_bb_reg_pkg::reg_dat_o, 8'h96, 1'b1, 8'hff, 1'b0);
    bus_cycle(1'b1, 1'b0, mmc_bb_reg_pkg::reg_dat_i, 8'h00, 1'b1, 8'hc3, 1'b1);

    for (int n = 0; n < n_trans; n++) begin
      rng = xorshift32(rng);
      bus_cycle(rng[3:0] != 4'd0, rng[4], rng[7:5], rng[15:8], rng[16], rng[31:24], rng[17]);
    end
    @(negedge lb_clk);

    $display("Checks: %0d, errors: %0d, pulses: %0d, dropped advances: %0d",
             checks, errors, pulses, dropped);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/mmc_bb_reg_pkg.sv
verilog/mmc_bb_seq_pkg.sv
verilog/mmc_line_if.sv
verilog/mmc_bb_regs.sv
verilog/mmc_clk_seq.sv
verilog/mmc_line_io.sv
verilog/mmc_bb.sv
bench/mmc_bb_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the MMC bit-bang testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module mmc_bb_tb -f verilog.f -o mmc_bb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/mmc_bb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qF 'All tests passed!'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
